// ==== source/rv_isa_pkg.sv ====
/*
 * RV32I instruction-set definitions: field widths, data types,
 * major opcodes and funct3 codes for branches and ALU operations
 */
`default_nettype none

package rv_isa_pkg;

	localparam int XLEN      = 32;
	localparam int REG_ADR_W = 5;
	localparam int NUM_REGS  = 32;
	localparam int OPCODE_W  = 7;
	localparam int FUNCT3_W  = 3;

	typedef logic [XLEN-1:0]      word_t;
	typedef logic [XLEN-1:0]      addr_t;
	typedef logic [REG_ADR_W-1:0] reg_adr_t;
	typedef logic [XLEN-1:0]      inst_t;

	localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
	localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;
	localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
	localparam logic [OPCODE_W-1:0] OP_JALR   = 7'b1100111;
	localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
	localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
	localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
	localparam logic [OPCODE_W-1:0] OP_ALUI   = 7'b0010011;
	localparam logic [OPCODE_W-1:0] OP_ALU    = 7'b0110011;

	// branch conditions
	localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

	// alu operations, SRL code also selects SRA via funct7
	localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
	localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_SRL  = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

endpackage

`default_nettype wire

// ==== source/cpu_ctrl_pkg.sv ====
/*
 * Core control definitions: execution phase encoding
 * and ALU operation encoding
 */
`default_nettype none

package cpu_ctrl_pkg;

	typedef enum logic [2:0] {
		PH_IDLE = 3'd0,
		PH_IF   = 3'd1, // instruction fetch
		PH_ID   = 3'd2, // decode and register read
		PH_EX   = 3'd3,
		PH_MA   = 3'd4, // data memory access
		PH_WB   = 3'd5
	} cpu_phase_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_t;

endpackage

`default_nettype wire

// ==== source/cpu_sequencer.sv ====
/*
 * Run/quit status flags and the phase state machine
 * that steps one instruction through IF, ID, EX, MA and WB
 */
`default_nettype none

module cpu_sequencer import cpu_ctrl_pkg::*; (
	input wire clk,
	input wire i_rst,
	input wire i_cpu_start,
	input wire i_quit_cmd,
	input wire i_imr_done,
	input wire i_ma_done,
	input wire i_wb_done,
	output cpu_phase_t o_phase
);

	logic running;
	logic quit_pend;
	logic to_idle;

	// stop only at an instruction boundary
	assign to_idle = (o_phase == PH_WB) && i_wb_done && (quit_pend || i_quit_cmd);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			running <= 1'b0;
			quit_pend <= 1'b0;
		end else if (to_idle) begin
			running <= 1'b0;
			quit_pend <= 1'b0;
		end else begin
			if (o_phase == PH_IDLE && i_cpu_start)
				running <= 1'b1;
			if (running && i_quit_cmd)
				quit_pend <= 1'b1; // held until WB ends
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_phase <= PH_IDLE;
		end else begin
			case (o_phase)
			PH_IDLE: if (i_cpu_start) o_phase <= PH_IF;
			PH_IF:   if (i_imr_done) o_phase <= PH_ID;
			PH_ID:   o_phase <= PH_EX;
			PH_EX:   o_phase <= PH_MA;
			PH_MA:   if (i_ma_done) o_phase <= PH_WB;
			PH_WB:   if (i_wb_done) o_phase <= to_idle ? PH_IDLE : PH_IF;
			default: o_phase <= PH_IDLE;
			endcase
		end
	end

	a_idle_needs_start: assert property (@(posedge clk) disable iff (i_rst)
		(o_phase == PH_IDLE && !i_cpu_start) |=> (o_phase == PH_IDLE));
	a_phase_legal: assert property (@(posedge clk) disable iff (i_rst)
		o_phase inside {PH_IDLE, PH_IF, PH_ID, PH_EX, PH_MA, PH_WB});

endmodule

`default_nettype wire

// ==== source/inst_fetch.sv ====
/*
 * Program counter and instruction memory read
 */
`default_nettype none

module inst_fetch import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input wire clk,
	input wire i_rst,
	input wire cpu_phase_t i_phase,
	input wire i_cpu_start,
	input wire logic [31:2] i_cpu_start_adr,
	input wire i_jmp_taken,
	input wire addr_t i_jmp_adr,
	input wire i_read_valid,
	input wire word_t i_read_data,
	output logic o_i_read_req,
	output addr_t o_i_read_adr,
	output addr_t o_pc,
	output inst_t o_inst,
	output logic o_imr_done
);

	assign o_i_read_req = (i_phase == PH_IF); // held until read valid
	assign o_i_read_adr = o_pc;
	assign o_imr_done = o_i_read_req && i_read_valid;

	always_ff @(posedge clk) begin
		if (i_rst)
			o_pc <= '0;
		else if (i_phase == PH_IDLE && i_cpu_start)
			o_pc <= {i_cpu_start_adr, 2'b00}; // word to byte address
		else if (i_phase == PH_WB)
			o_pc <= i_jmp_taken ? i_jmp_adr : o_pc + addr_t'(4);
	end

	always_ff @(posedge clk) begin
		if (o_imr_done)
			o_inst <= i_read_data;
	end

	a_iadr_stable: assert property (@(posedge clk) disable iff (i_rst)
		(o_i_read_req && !i_read_valid) |=> (o_i_read_req && $stable(o_i_read_adr)));

endmodule

`default_nettype wire

// ==== source/decoder.sv ====
/*
 * Instruction decoder: register fields, immediates,
 * ALU operation and command flags
 */
`default_nettype none

module decoder import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input wire inst_t i_inst,
	output reg_adr_t o_rs1_adr,
	output reg_adr_t o_rs2_adr,
	output reg_adr_t o_rd_adr,
	output word_t o_imm,
	output alu_op_t o_alu_op,
	output logic o_src_imm,
	output logic o_cmd_lui,
	output logic o_cmd_auipc,
	output logic o_cmd_jal,
	output logic o_cmd_jalr,
	output logic o_cmd_br,
	output logic [2:0] o_br_code,
	output logic o_cmd_ld,
	output logic o_cmd_st,
	output logic o_wbk_en
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic is_alu;
	logic is_alui;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];
	assign o_rs1_adr = i_inst[19:15];
	assign o_rs2_adr = i_inst[24:20];
	assign o_rd_adr = i_inst[11:7];
	assign o_br_code = funct3;

	assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
	assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
	assign imm_u = {i_inst[31:12], 12'd0};
	assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

	assign o_cmd_lui = (opcode == OP_LUI);
	assign o_cmd_auipc = (opcode == OP_AUIPC);
	assign o_cmd_jal = (opcode == OP_JAL);
	assign o_cmd_jalr = (opcode == OP_JALR);
	assign o_cmd_br = (opcode == OP_BRANCH);
	assign o_cmd_ld = (opcode == OP_LOAD);
	assign o_cmd_st = (opcode == OP_STORE);
	assign is_alu = (opcode == OP_ALU);
	assign is_alui = (opcode == OP_ALUI);
	assign o_src_imm = !is_alu; // only R-type uses rs2 as operand

	// branches, stores and unknown opcodes write nothing
	assign o_wbk_en = (o_cmd_lui || o_cmd_auipc || o_cmd_jal || o_cmd_jalr || o_cmd_ld
		|| is_alu || is_alui) && (o_rd_adr != '0);

	always_comb begin
		case (opcode)
		OP_LUI, OP_AUIPC: o_imm = imm_u;
		OP_JAL:           o_imm = imm_j;
		OP_BRANCH:        o_imm = imm_b;
		OP_STORE:         o_imm = imm_s;
		default:          o_imm = imm_i;
		endcase
	end

	always_comb begin
		o_alu_op = ALU_ADD; // address sums for jalr, load, store
		if (o_cmd_lui) begin
			o_alu_op = ALU_PASS_B;
		end else if (is_alu || is_alui) begin
			case (funct3)
			F3_ADD:  o_alu_op = (is_alu && i_inst[30]) ? ALU_SUB : ALU_ADD;
			F3_SLL:  o_alu_op = ALU_SLL;
			F3_SLT:  o_alu_op = ALU_SLT;
			F3_SLTU: o_alu_op = ALU_SLTU;
			F3_XOR:  o_alu_op = ALU_XOR;
			F3_SRL:  o_alu_op = i_inst[30] ? ALU_SRA : ALU_SRL;
			F3_OR:   o_alu_op = ALU_OR;
			F3_AND:  o_alu_op = ALU_AND;
			default: o_alu_op = ALU_ADD;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
/*
 * General register file x1..x31, x0 reads as zero
 */
`default_nettype none

module register_file import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input wire clk,
	input wire i_rst,
	input wire cpu_phase_t i_phase,
	input wire reg_adr_t i_rs1_adr,
	input wire reg_adr_t i_rs2_adr,
	input wire i_wbk_en,
	input wire reg_adr_t i_wbk_adr,
	input wire word_t i_wbk_data,
	output word_t o_rs1_data,
	output word_t o_rs2_data
);

	word_t regs [1:NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (i_wbk_en && i_wbk_adr != '0) begin
			regs[i_wbk_adr] <= i_wbk_data;
		end
	end

	// operands captured once per instruction
	always_ff @(posedge clk) begin
		if (i_phase == PH_ID) begin
			o_rs1_data <= (i_rs1_adr == '0) ? '0 : regs[i_rs1_adr];
			o_rs2_data <= (i_rs2_adr == '0) ? '0 : regs[i_rs2_adr];
		end
	end

endmodule

`default_nettype wire

// ==== source/execution.sv ====
/*
 * ALU, branch compare, jump targets and link address for the execute phase,
 * with results registered for the memory phase
 */
`default_nettype none

module execution import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input wire clk,
	input wire i_rst,
	input wire cpu_phase_t i_phase,
	input wire addr_t i_pc,
	input wire word_t i_rs1_data,
	input wire word_t i_rs2_data,
	input wire reg_adr_t i_rd_adr,
	input wire word_t i_imm,
	input wire alu_op_t i_alu_op,
	input wire i_src_imm,
	input wire i_cmd_lui,
	input wire i_cmd_auipc,
	input wire i_cmd_jal,
	input wire i_cmd_jalr,
	input wire i_cmd_br,
	input wire logic [2:0] i_br_code,
	input wire i_cmd_ld,
	input wire i_cmd_st,
	input wire i_wbk_en,
	output word_t o_result,
	output word_t o_store_data,
	output reg_adr_t o_rd_adr,
	output logic o_wbk_en,
	output logic o_cmd_ld,
	output logic o_cmd_st,
	output logic o_jmp_taken,
	output addr_t o_jmp_adr
);

	word_t opb, alu_out, pc_imm, pc_4, result;
	logic br_cond;

	assign opb = i_src_imm ? i_imm : i_rs2_data;
	assign pc_imm = i_pc + i_imm; // auipc, jal and branch target
	assign pc_4 = i_pc + word_t'(4);

	always_comb begin
		case (i_alu_op)
		ALU_ADD:    alu_out = i_rs1_data + opb;
		ALU_SUB:    alu_out = i_rs1_data - opb;
		ALU_SLL:    alu_out = i_rs1_data << opb[4:0];
		ALU_SLT:    alu_out = word_t'($signed(i_rs1_data) < $signed(opb));
		ALU_SLTU:   alu_out = word_t'(i_rs1_data < opb);
		ALU_XOR:    alu_out = i_rs1_data ^ opb;
		ALU_SRL:    alu_out = i_rs1_data >> opb[4:0];
		ALU_SRA:    alu_out = $signed(i_rs1_data) >>> opb[4:0];
		ALU_OR:     alu_out = i_rs1_data | opb;
		ALU_AND:    alu_out = i_rs1_data & opb;
		ALU_PASS_B: alu_out = opb; // lui
		default:    alu_out = '0;
		endcase
	end

	always_comb begin
		case (i_br_code)
		F3_BEQ:  br_cond = (i_rs1_data == i_rs2_data);
		F3_BNE:  br_cond = (i_rs1_data != i_rs2_data);
		F3_BLT:  br_cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
		F3_BGE:  br_cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
		F3_BLTU: br_cond = (i_rs1_data < i_rs2_data);
		F3_BGEU: br_cond = (i_rs1_data >= i_rs2_data);
		default: br_cond = 1'b0; // reserved codes fall through
		endcase
	end

	assign result = (i_cmd_jal || i_cmd_jalr) ? pc_4 : i_cmd_auipc ? pc_imm : alu_out;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_wbk_en <= 1'b0;
			o_cmd_ld <= 1'b0;
			o_cmd_st <= 1'b0;
			o_jmp_taken <= 1'b0;
		end else if (i_phase == PH_EX) begin
			o_wbk_en <= i_wbk_en;
			o_cmd_ld <= i_cmd_ld;
			o_cmd_st <= i_cmd_st;
			o_jmp_taken <= i_cmd_jal || i_cmd_jalr || (i_cmd_br && br_cond);
		end
	end

	always_ff @(posedge clk) begin
		if (i_phase == PH_EX) begin
			o_result <= result; // also the load/store address
			o_store_data <= i_rs2_data;
			o_rd_adr <= i_rd_adr;
			o_jmp_adr <= i_cmd_jalr ? {alu_out[31:1], 1'b0} : pc_imm;
		end
	end

endmodule

`default_nettype wire

// ==== source/data_rw_mem.sv ====
/*
 * Memory access phase: word load/store requests,
 * write-back data select and register write strobe
 */
`default_nettype none

module data_rw_mem import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input wire clk,
	input wire i_rst,
	input wire cpu_phase_t i_phase,
	input wire word_t i_result,
	input wire word_t i_store_data,
	input wire reg_adr_t i_rd_adr,
	input wire i_wbk_en,
	input wire i_cmd_ld,
	input wire i_cmd_st,
	input wire i_read_valid,
	input wire word_t i_read_data,
	input wire i_write_finish,
	output logic o_d_read_req,
	output addr_t o_d_read_adr,
	output logic o_d_write_req,
	output addr_t o_d_write_adr,
	output word_t o_d_write_data,
	output logic o_ma_done,
	output logic o_wbk_en,
	output reg_adr_t o_wbk_adr,
	output word_t o_wbk_data,
	output logic o_wb_done
);

	word_t ld_data;

	assign o_d_read_req = (i_phase == PH_MA) && i_cmd_ld;
	assign o_d_write_req = (i_phase == PH_MA) && i_cmd_st;
	assign o_d_read_adr = i_result;
	assign o_d_write_adr = i_result;
	assign o_d_write_data = i_store_data;

	// other instructions pass through MA in one cycle
	assign o_ma_done = (i_phase == PH_MA) && (i_cmd_ld ? i_read_valid :
		i_cmd_st ? i_write_finish : 1'b1);

	always_ff @(posedge clk) begin
		if (o_d_read_req && i_read_valid)
			ld_data <= i_read_data;
	end

	assign o_wbk_en = (i_phase == PH_WB) && i_wbk_en;
	assign o_wbk_adr = i_rd_adr;
	assign o_wbk_data = i_cmd_ld ? ld_data : i_result;
	assign o_wb_done = (i_phase == PH_WB);

	a_rw_exclusive: assert property (@(posedge clk) disable iff (i_rst)
		!(o_d_read_req && o_d_write_req));

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
/*
 * RV32I multi-cycle core top level joining the sequencer, fetch, decode,
 * register file, execute and memory access blocks
 */
`default_nettype none

module cpu_top import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input wire clk,
	input wire i_rst,
	input wire i_cpu_start,
	input wire logic [31:2] i_cpu_start_adr,
	input wire i_quit_cmd,
	output addr_t o_pc_data,
	output logic o_i_read_req,
	output addr_t o_i_read_adr,
	output logic o_d_read_req,
	output addr_t o_d_read_adr,
	input wire i_read_valid,
	input wire word_t i_read_data,
	output logic o_d_write_req,
	output addr_t o_d_write_adr,
	output word_t o_d_write_data,
	input wire i_write_finish
);

	cpu_phase_t phase;
	logic imr_done, ma_done, wb_done;
	inst_t inst;
	reg_adr_t rs1_adr, rs2_adr, dec_rd_adr, ma_rd_adr, wbk_adr;
	word_t imm, rs1_data, rs2_data, result, store_data, wbk_data;
	alu_op_t alu_op;
	logic src_imm, cmd_lui, cmd_auipc, cmd_jal, cmd_jalr, cmd_br;
	logic [2:0] br_code;
	logic dec_cmd_ld, dec_cmd_st, dec_wbk_en;
	logic ma_cmd_ld, ma_cmd_st, ma_wbk_en, wbk_en;
	logic jmp_taken;
	addr_t jmp_adr;

	cpu_sequencer cpu_sequencer (
		.clk(clk), .i_rst(i_rst), .i_cpu_start(i_cpu_start), .i_quit_cmd(i_quit_cmd),
		.i_imr_done(imr_done), .i_ma_done(ma_done), .i_wb_done(wb_done), .o_phase(phase));

	inst_fetch inst_fetch (
		.clk(clk), .i_rst(i_rst), .i_phase(phase), .i_cpu_start(i_cpu_start),
		.i_cpu_start_adr(i_cpu_start_adr), .i_jmp_taken(jmp_taken), .i_jmp_adr(jmp_adr),
		.i_read_valid(i_read_valid), .i_read_data(i_read_data),
		.o_i_read_req(o_i_read_req), .o_i_read_adr(o_i_read_adr), .o_pc(o_pc_data),
		.o_inst(inst), .o_imr_done(imr_done));

	decoder decoder (
		.i_inst(inst), .o_rs1_adr(rs1_adr), .o_rs2_adr(rs2_adr), .o_rd_adr(dec_rd_adr),
		.o_imm(imm), .o_alu_op(alu_op), .o_src_imm(src_imm), .o_cmd_lui(cmd_lui),
		.o_cmd_auipc(cmd_auipc), .o_cmd_jal(cmd_jal), .o_cmd_jalr(cmd_jalr),
		.o_cmd_br(cmd_br), .o_br_code(br_code), .o_cmd_ld(dec_cmd_ld),
		.o_cmd_st(dec_cmd_st), .o_wbk_en(dec_wbk_en));

	register_file register_file (
		.clk(clk), .i_rst(i_rst), .i_phase(phase), .i_rs1_adr(rs1_adr),
		.i_rs2_adr(rs2_adr), .i_wbk_en(wbk_en), .i_wbk_adr(wbk_adr),
		.i_wbk_data(wbk_data), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data));

	execution execution (
		.clk(clk), .i_rst(i_rst), .i_phase(phase), .i_pc(o_pc_data),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_rd_adr(dec_rd_adr), .i_imm(imm),
		.i_alu_op(alu_op), .i_src_imm(src_imm), .i_cmd_lui(cmd_lui),
		.i_cmd_auipc(cmd_auipc), .i_cmd_jal(cmd_jal), .i_cmd_jalr(cmd_jalr),
		.i_cmd_br(cmd_br), .i_br_code(br_code), .i_cmd_ld(dec_cmd_ld),
		.i_cmd_st(dec_cmd_st), .i_wbk_en(dec_wbk_en), .o_result(result),
		.o_store_data(store_data), .o_rd_adr(ma_rd_adr), .o_wbk_en(ma_wbk_en),
		.o_cmd_ld(ma_cmd_ld), .o_cmd_st(ma_cmd_st), .o_jmp_taken(jmp_taken),
		.o_jmp_adr(jmp_adr));

	// fetch and load never overlap on the shared read response bus
	data_rw_mem data_rw_mem (
		.clk(clk), .i_rst(i_rst), .i_phase(phase), .i_result(result),
		.i_store_data(store_data), .i_rd_adr(ma_rd_adr), .i_wbk_en(ma_wbk_en),
		.i_cmd_ld(ma_cmd_ld), .i_cmd_st(ma_cmd_st), .i_read_valid(i_read_valid),
		.i_read_data(i_read_data), .i_write_finish(i_write_finish),
		.o_d_read_req(o_d_read_req), .o_d_read_adr(o_d_read_adr),
		.o_d_write_req(o_d_write_req), .o_d_write_adr(o_d_write_adr),
		.o_d_write_data(o_d_write_data), .o_ma_done(ma_done), .o_wbk_en(wbk_en),
		.o_wbk_adr(wbk_adr), .o_wbk_data(wbk_data), .o_wb_done(wb_done));

endmodule

`default_nettype wire

// ==== verif/tb_cpu_top.sv ====
/*
 * Testbench for the multi-cycle core: random program generator, instruction
 * and data memory models with random latency, ISA reference model and checks
 */
`default_nettype none

module tb_cpu_top import rv_isa_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PROG_LEN = 200;
	localparam logic [29:0] START_WADR = 30'h40;
	localparam addr_t PROG_BASE = 32'h100;
	localparam addr_t PROG_END = PROG_BASE + 32'(PROG_LEN * 4);
	localparam addr_t DBASE = 32'h700; // 16-word data window
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk = 1'b0;
	logic i_rst;
	logic i_cpu_start;
	logic [29:0] i_cpu_start_adr;
	logic i_quit_cmd = 1'b0;
	logic i_read_valid = 1'b0;
	word_t i_read_data = '0;
	logic i_write_finish = 1'b0;
	addr_t o_pc_data, o_i_read_adr, o_d_read_adr, o_d_write_adr;
	word_t o_d_write_data;
	logic o_i_read_req, o_d_read_req, o_d_write_req;

	word_t imem [512];
	word_t dmem [16];
	word_t dmodel [16];
	word_t xreg [32];
	addr_t exp_pc [$];
	addr_t exp_ld [$];
	addr_t exp_st_adr [$];
	word_t exp_st_dat [$];
	addr_t final_pc;
	logic [31:0] lfsr_state;
	int prog_n;
	int cycle_cnt = 0;
	logic started = 1'b0;
	logic pending = 1'b0; // a memory request is being served
	logic [1:0] cur_kind; // 0 fetch, 1 load, 2 store
	addr_t cur_adr;
	word_t cur_data;
	logic [1:0] wait_left;

	cpu_top uut (
		.clk(clk), .i_rst(i_rst), .i_cpu_start(i_cpu_start),
		.i_cpu_start_adr(i_cpu_start_adr), .i_quit_cmd(i_quit_cmd), .o_pc_data(o_pc_data),
		.o_i_read_req(o_i_read_req), .o_i_read_adr(o_i_read_adr),
		.o_d_read_req(o_d_read_req), .o_d_read_adr(o_d_read_adr),
		.i_read_valid(i_read_valid), .i_read_data(i_read_data),
		.o_d_write_req(o_d_write_req), .o_d_write_adr(o_d_write_adr),
		.o_d_write_data(o_d_write_data), .i_write_finish(i_write_finish));

	always #10 clk = ~clk;

	task automatic stop_on_failure(input string line);
		$display("%s", line);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic word_t enc_i(logic [11:0] imm, reg_adr_t rs1, logic [2:0] f3,
		reg_adr_t rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t enc_r(logic [6:0] f7, reg_adr_t rs2, reg_adr_t rs1,
		logic [2:0] f3, reg_adr_t rd);
		return {f7, rs2, rs1, f3, rd, OP_ALU};
	endfunction

	function automatic word_t enc_s(logic [11:0] imm, reg_adr_t rs2, reg_adr_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t enc_b(logic [12:0] imm, reg_adr_t rs2, reg_adr_t rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic word_t enc_j(logic [20:0] imm, reg_adr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	task automatic put_inst(input word_t inst);
		if (prog_n < PROG_LEN) begin
			imem[9'(START_WADR) + 9'(prog_n)] = inst;
			prog_n++;
		end
	endtask

	// forward control flow only, so the program always runs to its end
	task automatic build_program();
		reg_adr_t rd, rs1, rs2;
		logic [2:0] f3, kind;
		logic [11:0] imm;
		int skip;
		addr_t target;
		prog_n = 0;
		while (prog_n < PROG_LEN) begin
			kind = 3'(rand_bits(3));
			rd = 5'(rand_bits(5));
			rs1 = 5'(rand_bits(5));
			rs2 = 5'(rand_bits(5));
			f3 = 3'(rand_bits(3));
			imm = 12'(rand_bits(12));
			skip = 1 + int'(rand_bits(2));
			if (skip > PROG_LEN - prog_n - 1)
				skip = PROG_LEN - prog_n - 1; // never past the program end
			target = PROG_BASE + 32'((prog_n + 1 + skip) * 4);
			case (kind)
			3'd0, 3'd1: put_inst(enc_r((f3 == F3_ADD || f3 == F3_SRL) ? {1'b0, imm[0], 5'd0} :
				7'd0, rs2, rs1, f3, rd));
			3'd2, 3'd3: begin
				if (f3 == F3_SLL || f3 == F3_SRL)
					imm = {1'b0, imm[10] & (f3 == F3_SRL), 5'd0, imm[4:0]}; // shamt form
				put_inst(enc_i(imm, rs1, f3, rd, OP_ALUI));
			end
			3'd4: put_inst({imm, rs1, rs2[2:0], rd, imm[0] ? OP_LUI : OP_AUIPC});
			3'd5: put_inst(enc_i({6'b011100, rs1[3:0], 2'b00}, 5'd0, 3'b010, rd, OP_LOAD));
			3'd6: begin
				if (f3 == 3'd2 || f3 == 3'd3)
					f3 = {2'b00, f3[0]}; // no branch on codes 2 and 3
				put_inst(enc_b(13'((skip + 1) * 4), rs2, rs1, f3));
			end
			default: begin
				if (imm[0])
					put_inst(enc_j(21'((skip + 1) * 4), rd));
				else
					put_inst(enc_i(target[11:0], 5'd0, 3'b000, rd, OP_JALR));
				repeat (skip)
					put_inst(enc_i(imm, rs1, F3_XOR, rs2, OP_ALUI)); // jumped over
			end
			endcase
			if (kind != 3'd6)
				put_inst(enc_s({6'b011100, rs2[3:0], 2'b00}, rd, 5'd0)); // store rd
		end
	endtask

	function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
		case (f3)
		F3_ADD:  return alt ? a - b : a + b;
		F3_SLL:  return a << b[4:0];
		F3_SLT:  return {31'd0, $signed(a) < $signed(b)};
		F3_SLTU: return {31'd0, a < b};
		F3_XOR:  return a ^ b;
		F3_SRL:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
		F3_OR:   return a | b;
		default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
		case (f3)
		F3_BEQ:  return a == b;
		F3_BNE:  return a != b;
		F3_BLT:  return $signed(a) < $signed(b);
		F3_BGE:  return $signed(a) >= $signed(b);
		F3_BLTU: return a < b;
		F3_BGEU: return a >= b;
		default: return 1'b0;
		endcase
	endfunction

	task automatic set_reg(input reg_adr_t rd, input word_t v);
		if (rd != 5'd0)
			xreg[rd] = v;
	endtask

	// architectural run of the program, fills the expected event queues
	task automatic run_model();
		addr_t pc, nxt, t;
		word_t ins, a, b, imm_i, imm_s, imm_b, imm_j;
		reg_adr_t rd;
		logic [2:0] f3;
		pc = PROG_BASE;
		while (pc < PROG_END) begin
			exp_pc.push_back(pc);
			ins = imem[pc[10:2]];
			rd = ins[11:7];
			f3 = ins[14:12];
			a = xreg[ins[19:15]];
			b = xreg[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			nxt = pc + 32'd4;
			case (ins[6:0])
			OP_LUI:    set_reg(rd, {ins[31:12], 12'd0});
			OP_AUIPC:  set_reg(rd, pc + {ins[31:12], 12'd0});
			OP_JAL: begin
				set_reg(rd, pc + 32'd4);
				nxt = pc + imm_j;
			end
			OP_JALR: begin
				nxt = (a + imm_i) & ~32'd1;
				set_reg(rd, pc + 32'd4);
			end
			OP_BRANCH: if (branch_taken(f3, a, b)) nxt = pc + imm_b;
			OP_LOAD: begin
				t = a + imm_i;
				exp_ld.push_back(t);
				set_reg(rd, dmodel[t[5:2]]);
			end
			OP_STORE: begin
				t = a + imm_s;
				exp_st_adr.push_back(t);
				exp_st_dat.push_back(b);
				dmodel[t[5:2]] = b;
			end
			OP_ALUI:   set_reg(rd, alu_ref(f3, ins[30] && f3 == F3_SRL, a, imm_i));
			OP_ALU:    set_reg(rd, alu_ref(f3, ins[30], a, b));
			default:   ;
			endcase
			pc = nxt;
		end
		final_pc = pc;
	endtask

	task automatic check_request(input logic [1:0] kind, input addr_t adr);
		if (kind == 2'd0) begin
			assert (exp_pc.size() > 0) else stop_on_failure($sformatf(
				"instruction fetch at %0t ns after the last instruction", $time));
			assert (adr == exp_pc[0]) else stop_on_failure($sformatf(
				"Error at %0t ns: fetch address %h, expected %h", $time, adr, exp_pc[0]));
			void'(exp_pc.pop_front());
			if (exp_pc.size() == 0)
				i_quit_cmd = 1'b1; // stop after the last instruction
		end else begin
			assert (adr >= DBASE && adr < DBASE + 32'd64) else stop_on_failure($sformatf(
				"Error at %0t ns: data address %h outside the data window", $time, adr));
		end
		if (kind == 2'd1) begin
			assert (exp_ld.size() > 0) else stop_on_failure($sformatf(
				"load at %0t ns that the program does not contain", $time));
			assert (adr == exp_ld[0]) else stop_on_failure($sformatf(
				"Error at %0t ns: load address %h, expected %h", $time, adr, exp_ld[0]));
			void'(exp_ld.pop_front());
		end else if (kind == 2'd2) begin
			assert (exp_st_adr.size() > 0) else stop_on_failure($sformatf(
				"store at %0t ns that the program does not contain", $time));
			assert (adr == exp_st_adr[0] && o_d_write_data == exp_st_dat[0])
				else stop_on_failure($sformatf("Error at %0t ns: store %h to %h, expected %h to %h",
				$time, o_d_write_data, adr, exp_st_dat[0], exp_st_adr[0]));
			void'(exp_st_adr.pop_front());
			void'(exp_st_dat.pop_front());
		end
	endtask

	task automatic respond();
		case (cur_kind)
		2'd0: begin
			i_read_data = imem[cur_adr[10:2]];
			i_read_valid = 1'b1;
		end
		2'd1: begin
			i_read_data = dmem[cur_adr[5:2]];
			i_read_valid = 1'b1;
		end
		default: begin
			dmem[cur_adr[5:2]] = cur_data;
			i_write_finish = 1'b1;
		end
		endcase
		pending = 1'b0;
	endtask

	task automatic serve_memory();
		logic any_req;
		logic [1:0] kind;
		addr_t adr;
		any_req = o_i_read_req || o_d_read_req || o_d_write_req;
		kind = o_d_write_req ? 2'd2 : o_d_read_req ? 2'd1 : 2'd0;
		adr = o_d_write_req ? o_d_write_adr : o_d_read_req ? o_d_read_adr : o_i_read_adr;
		assert (!(o_d_read_req && o_d_write_req) && !(o_i_read_req && (o_d_read_req ||
			o_d_write_req))) else stop_on_failure($sformatf(
			"more than one memory request high at %0t ns", $time));
		assert (started || !any_req) else stop_on_failure($sformatf(
			"memory request at %0t ns before any start pulse", $time));
		if (pending) begin
			assert (any_req && kind == cur_kind && adr == cur_adr &&
				(kind != 2'd2 || o_d_write_data == cur_data)) else stop_on_failure($sformatf(
				"request at %0t ns dropped or changed before its response", $time));
		end else if (any_req) begin
			pending = 1'b1;
			cur_kind = kind;
			cur_adr = adr;
			cur_data = o_d_write_data;
			wait_left = 2'(rand_bits(2)); // 1 to 4 cycles
			check_request(kind, adr);
		end
		if (pending) begin
			if (wait_left == 2'd0)
				respond();
			else
				wait_left = wait_left - 2'd1;
		end
	endtask

	always @(negedge clk) begin
		i_read_valid = 1'b0;
		i_write_finish = 1'b0;
		i_quit_cmd = 1'b0;
		if (!i_rst)
			serve_memory();
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			stop_on_failure("timeout, the core did not finish the program in 4000 cycles");
	end

	initial begin
		i_rst = 1'b1;
		i_cpu_start = 1'b0;
		i_cpu_start_adr = START_WADR;
		lfsr_state = 32'h8b5a;
		for (int i = 0; i < 512; i++)
			imem[9'(i)] = {25'(i), 7'b0001011}; // unsupported opcode outside the program
		for (int i = 0; i < 16; i++) begin
			dmem[4'(i)] = (DBASE + 32'(i * 4)) * 32'h9e3779b1;
			dmodel[4'(i)] = (DBASE + 32'(i * 4)) * 32'h9e3779b1;
		end
		for (int i = 0; i < 32; i++)
			xreg[5'(i)] = '0;
		build_program();
		run_model();
		repeat (10) @(negedge clk);
		i_rst = 1'b0;
		repeat (20) @(negedge clk); // idle, no requests allowed
		i_cpu_start = 1'b1;
		started = 1'b1;
		@(negedge clk);
		i_cpu_start = 1'b0;
		while (exp_pc.size() != 0 || exp_ld.size() != 0 || exp_st_adr.size() != 0)
			@(negedge clk);
		repeat (30) @(negedge clk); // last instruction retires, core stays idle
		assert (!pending && o_pc_data == final_pc) else stop_on_failure($sformatf(
			"Error at %0t ns: final pc %h, expected %h", $time, o_pc_data, final_pc));
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== cpu_top.f ====
source/rv_isa_pkg.sv
source/cpu_ctrl_pkg.sv
source/cpu_sequencer.sv
source/inst_fetch.sv
source/decoder.sv
source/register_file.sv
source/execution.sv
source/data_rw_mem.sv
source/cpu_top.sv
verif/tb_cpu_top.sv

// ==== Makefile ====
TOP = tb_cpu_top

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f cpu_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only -Wall --timing --assert --top-module cpu_top -f cpu_top.f

clean:
	rm -rf obj_dir
